// ==== include/atop_defs.svh ====
// AXI subsystem parameters

`ifndef ATOP_DEFS_SVH
`define ATOP_DEFS_SVH

// AXI ID width in bits
`define ATOP_ID_W 4

// Byte address width
`define ATOP_ADDR_W 12

// Data bus width, full-width transfers only
`define ATOP_DATA_W 32

// Memory depth in bus words
`define ATOP_MEM_WORDS 256

// Downstream write bursts allowed in flight
`define ATOP_MAX_WTXNS 2

`endif

// ==== logic/atop_axi_pkg.sv ====
// AXI channel types

`default_nettype none

`include "atop_defs.svh"

package atop_axi_pkg;

  // Basic field types
  typedef logic [`ATOP_ID_W-1:0]     id_t;
  typedef logic [`ATOP_ADDR_W-1:0]   addr_t;
  typedef logic [`ATOP_DATA_W-1:0]   data_t;
  typedef logic [`ATOP_DATA_W/8-1:0] strb_t;
  typedef logic [7:0]                len_t;
  typedef logic [5:0]                atop_t;
  typedef logic [1:0]                resp_code_t;

  // Upper atop bits select the atomic kind
  localparam logic [1:0] ATOP_NONE        = 2'b00;
  localparam logic [1:0] ATOP_ATOMICSTORE = 2'b01;
  localparam logic [1:0] ATOP_ATOMICLOAD  = 2'b10;

  localparam resp_code_t RESP_OKAY   = 2'b00;
  localparam resp_code_t RESP_SLVERR = 2'b10;

  // Full bus width beats, incrementing bursts
  localparam logic [2:0] SIZE_FULL  = 3'($clog2(`ATOP_DATA_W/8));
  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    atop_t      atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    resp_code_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    resp_code_t resp;
    logic       last;
  } r_chan_t;

  // Master to slave bundle
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Slave to master bundle
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Pending R injection, beats minus one
  typedef struct packed {
    len_t len;
  } r_cmd_t;

endpackage

`default_nettype wire

// ==== logic/axi_chan_if.sv ====
// AXI channel bundle interface

`timescale 1ns/1ps
`default_nettype none

interface axi_chan_if;

  // All five channels, requests flow downstream
  atop_axi_pkg::axi_req_t  req;

  // Ready signals and B/R payloads flow upstream
  atop_axi_pkg::axi_resp_t resp;

  // Initiator side of a link
  modport mst (
    output req,
    input  resp
  );

  // Target side of a link
  modport slv (
    input  req,
    output resp
  );

endinterface

`default_nettype wire

// ==== logic/stream_reg.sv ====
// Single-entry stream register

`timescale 1ns/1ps
`default_nettype none

module stream_reg #(
  parameter type payload_t = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // Input side
  input  wire logic valid_i,
  output logic      ready_o,
  input  payload_t  data_i,
  // Output side
  output logic      valid_o,
  input  wire logic ready_i,
  output payload_t  data_o
);

  logic     full_q;
  payload_t data_q;

  // Accept only into an empty slot
  assign ready_o = ~full_q;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      full_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload captured on push
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // Offered entry must be held until taken
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_o |=> valid_i && $stable(data_i));

endmodule

`default_nettype wire

// ==== logic/atop_filter.sv ====
// AXI atomic operation filter

`timescale 1ns/1ps
`default_nettype none

`include "atop_defs.svh"

module atop_filter (
  input wire logic clk_i,
  input wire logic rst_ni,
  axi_chan_if.slv  slv,
  axi_chan_if.mst  mst
);

  typedef logic [$clog2(`ATOP_MAX_WTXNS+1)-1:0] cnt_t;
  localparam cnt_t MaxCnt = cnt_t'(`ATOP_MAX_WTXNS);

  typedef enum logic [2:0] {W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, INJECT_B, WAIT_R} w_state_t;
  typedef enum logic {R_FEEDTHROUGH, INJECT_R} r_state_t;

  w_state_t w_state_d, w_state_q;
  r_state_t r_state_d, r_state_q;
  cnt_t     w_cnt_d, w_cnt_q;
  atop_axi_pkg::id_t  id_d, id_q;
  atop_axi_pkg::len_t r_beats_d, r_beats_q;

  // Filtered channel signals
  logic mst_aw_valid, slv_aw_ready, mst_w_valid, slv_w_ready;
  logic mst_b_ready, slv_b_valid, mst_r_ready, slv_r_valid;
  atop_axi_pkg::b_chan_t  slv_b;
  atop_axi_pkg::r_chan_t  slv_r;
  atop_axi_pkg::aw_chan_t aw_fwd;
  logic [1:0] aw_kind;

  // R injection command queue
  logic r_cmd_push_valid, r_cmd_push_ready, r_cmd_valid, r_cmd_pop_ready;
  atop_axi_pkg::r_cmd_t r_cmd_push, r_cmd;

  assign aw_kind = slv.req.aw.atop[5:4];
  assign r_cmd_push.len = slv.req.aw.len;

  // Write path FSM
  always_comb begin
    mst_aw_valid = 1'b0;
    slv_aw_ready = 1'b0;
    mst_w_valid  = 1'b0;
    slv_w_ready  = 1'b0;
    // B passes through unless injecting
    mst_b_ready  = slv.req.b_ready;
    slv_b_valid  = mst.resp.b_valid;
    slv_b        = mst.resp.b;
    id_d         = id_q;
    r_cmd_push_valid = 1'b0;
    w_state_d    = w_state_q;
    unique case (w_state_q)
      W_FEEDTHROUGH: begin
        if (w_cnt_q < MaxCnt) begin
          mst_aw_valid = slv.req.aw_valid;
          slv_aw_ready = mst.resp.aw_ready;
        end
        // W only behind a forwarded AW
        if (w_cnt_q != '0) begin
          mst_w_valid = slv.req.w_valid;
          slv_w_ready = mst.resp.w_ready;
        end
        if (slv.req.aw_valid && aw_kind != atop_axi_pkg::ATOP_NONE) begin
          mst_aw_valid = 1'b0;
          slv_aw_ready = 1'b0;
          if (r_cmd_push_ready) begin
            slv_aw_ready = 1'b1;
            id_d = slv.req.aw.id;
            // Stores get no R response
            r_cmd_push_valid = (aw_kind != atop_axi_pkg::ATOP_ATOMICSTORE);
            if (w_cnt_q != '0) begin
              w_state_d = BLOCK_AW;
            end else begin
              slv_w_ready = 1'b1;
              w_state_d = (slv.req.w_valid && slv.req.w.last) ? INJECT_B : ABSORB_W;
            end
          end
        end
      end
      BLOCK_AW: begin
        // Drain older bursts first
        if (w_cnt_q != '0) begin
          mst_w_valid = slv.req.w_valid;
          slv_w_ready = mst.resp.w_ready;
        end else begin
          slv_w_ready = 1'b1;
          w_state_d = (slv.req.w_valid && slv.req.w.last) ? INJECT_B : ABSORB_W;
        end
      end
      ABSORB_W: begin
        slv_w_ready = 1'b1;
        if (slv.req.w_valid && slv.req.w.last) begin
          w_state_d = INJECT_B;
        end
      end
      INJECT_B: begin
        mst_b_ready = 1'b0;
        slv_b_valid = 1'b1;
        slv_b.id    = id_q;
        slv_b.resp  = atop_axi_pkg::RESP_SLVERR;
        if (slv.req.b_ready) begin
          // Wait for the R beats still to be sent
          w_state_d = (r_cmd_valid && !r_cmd_pop_ready) ? WAIT_R : W_FEEDTHROUGH;
        end
      end
      WAIT_R: begin
        if (!r_cmd_valid) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end
      default: w_state_d = W_FEEDTHROUGH;
    endcase
  end

  // Read path FSM, injected beats take over R
  always_comb begin
    slv_r_valid     = mst.resp.r_valid;
    slv_r           = mst.resp.r;
    mst_r_ready     = slv.req.r_ready;
    r_cmd_pop_ready = 1'b0;
    r_beats_d       = r_beats_q;
    r_state_d       = r_state_q;
    unique case (r_state_q)
      R_FEEDTHROUGH: begin
        if (r_cmd_push_valid) begin
          r_state_d = INJECT_R;
        end
      end
      INJECT_R: begin
        mst_r_ready = 1'b0;
        slv_r_valid = 1'b1;
        slv_r       = '0;
        slv_r.id    = id_q;
        slv_r.resp  = atop_axi_pkg::RESP_SLVERR;
        slv_r.last  = (r_beats_q == r_cmd.len);
        if (slv.req.r_ready) begin
          if (slv_r.last) begin
            r_cmd_pop_ready = 1'b1;
            r_beats_d = '0;
            r_state_d = R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q + 8'd1;
          end
        end
      end
      default: r_state_d = R_FEEDTHROUGH;
    endcase
  end

  // Outstanding downstream write bursts
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_aw_valid && mst.resp.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (mst_w_valid && mst.resp.w_ready && slv.req.w.last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  // Downstream AW never carries atop
  always_comb begin
    aw_fwd      = slv.req.aw;
    aw_fwd.atop = '0;
  end

  assign mst.req.aw       = aw_fwd;
  assign mst.req.aw_valid = mst_aw_valid;
  assign mst.req.w        = slv.req.w;
  assign mst.req.w_valid  = mst_w_valid;
  assign mst.req.b_ready  = mst_b_ready;
  assign mst.req.ar       = slv.req.ar;
  assign mst.req.ar_valid = slv.req.ar_valid;
  assign mst.req.r_ready  = mst_r_ready;

  assign slv.resp.aw_ready = slv_aw_ready;
  assign slv.resp.w_ready  = slv_w_ready;
  assign slv.resp.b        = slv_b;
  assign slv.resp.b_valid  = slv_b_valid;
  assign slv.resp.ar_ready = mst.resp.ar_ready;
  assign slv.resp.r        = slv_r;
  assign slv.resp.r_valid  = slv_r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_FEEDTHROUGH;
      r_state_q <= R_FEEDTHROUGH;
      w_cnt_q   <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      r_beats_q <= r_beats_d;
    end
  end

  // Atomic ID for both injected responses
  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end

  stream_reg #(
    .payload_t (atop_axi_pkg::r_cmd_t)
  ) r_cmd_reg_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (r_cmd_push_valid),
    .ready_o (r_cmd_push_ready),
    .data_i  (r_cmd_push),
    .valid_o (r_cmd_valid),
    .ready_i (r_cmd_pop_ready),
    .data_o  (r_cmd)
  );

  // No atomic AW is ever forwarded downstream
  a_dn_atop_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst.req.aw_valid |-> aw_kind == atop_axi_pkg::ATOP_NONE && mst.req.aw.atop == '0);

  a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_cnt_q <= MaxCnt);

endmodule

`default_nettype wire

// ==== logic/burst_mem.sv ====
// AXI burst memory

`timescale 1ns/1ps
`default_nettype none

`include "atop_defs.svh"

module burst_mem (
  input wire logic clk_i,
  input wire logic rst_ni,
  axi_chan_if.slv  slv
);

  localparam int unsigned Words = `ATOP_MEM_WORDS;
  localparam int unsigned IdxW  = $clog2(Words);
  localparam int unsigned OffW  = $clog2(`ATOP_DATA_W/8);
  localparam int unsigned StrbW = `ATOP_DATA_W/8;

  typedef logic [IdxW-1:0] idx_t;

  atop_axi_pkg::data_t mem_q [Words];

  // Write side
  logic w_busy_q;
  idx_t w_idx_q;
  atop_axi_pkg::id_t w_id_q;
  logic aw_hs, w_hs;
  logic b_push_valid, b_push_ready;
  atop_axi_pkg::b_chan_t b_push;

  // Read side
  logic r_busy_q;
  idx_t r_idx_q;
  atop_axi_pkg::id_t  r_id_q;
  atop_axi_pkg::len_t r_len_q, r_beat_q;
  logic ar_hs, r_hs, r_last;

  // Next AW only once the previous B has left
  assign slv.resp.aw_ready = ~w_busy_q & b_push_ready;
  assign slv.resp.w_ready  = w_busy_q;
  assign aw_hs = slv.req.aw_valid & slv.resp.aw_ready;
  assign w_hs  = slv.req.w_valid & w_busy_q;

  // B queued on the last beat
  assign b_push_valid = w_hs & slv.req.w.last;
  assign b_push.id    = w_id_q;
  assign b_push.resp  = atop_axi_pkg::RESP_OKAY;

  assign slv.resp.ar_ready = ~r_busy_q;
  assign ar_hs  = slv.req.ar_valid & ~r_busy_q;
  assign r_last = (r_beat_q == r_len_q);
  assign r_hs   = r_busy_q & slv.req.r_ready;

  assign slv.resp.r_valid = r_busy_q;
  assign slv.resp.r.id    = r_id_q;
  assign slv.resp.r.data  = mem_q[r_idx_q];
  assign slv.resp.r.resp  = atop_axi_pkg::RESP_OKAY;
  assign slv.resp.r.last  = r_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_busy_q <= 1'b0;
      r_busy_q <= 1'b0;
      r_beat_q <= '0;
    end else begin
      if (aw_hs) begin
        w_busy_q <= 1'b1;
      end else if (b_push_valid) begin
        w_busy_q <= 1'b0;
      end
      if (ar_hs) begin
        r_busy_q <= 1'b1;
        r_beat_q <= '0;
      end else if (r_hs) begin
        r_busy_q <= ~r_last;
        r_beat_q <= r_beat_q + 8'd1;
      end
    end
  end

  // Burst address and ID tracking, word index wraps at the depth
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      w_idx_q <= slv.req.aw.addr[OffW +: IdxW];
      w_id_q  <= slv.req.aw.id;
    end else if (w_hs) begin
      w_idx_q <= w_idx_q + idx_t'(1);
    end
    if (ar_hs) begin
      r_idx_q <= slv.req.ar.addr[OffW +: IdxW];
      r_id_q  <= slv.req.ar.id;
      r_len_q <= slv.req.ar.len;
    end else if (r_hs) begin
      r_idx_q <= r_idx_q + idx_t'(1);
    end
  end

  // Byte lanes under strobe
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      for (int unsigned i = 0; i < StrbW; i++) begin
        if (slv.req.w.strb[i]) begin
          mem_q[w_idx_q][8*i +: 8] <= slv.req.w.data[8*i +: 8];
        end
      end
    end
  end

  stream_reg #(
    .payload_t (atop_axi_pkg::b_chan_t)
  ) b_reg_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (b_push_valid),
    .ready_o (b_push_ready),
    .data_i  (b_push),
    .valid_o (slv.resp.b_valid),
    .ready_i (slv.req.b_ready),
    .data_o  (slv.resp.b)
  );

  // Atomics must be stripped upstream
  a_no_atop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_hs |-> slv.req.aw.atop == '0);

endmodule

`default_nettype wire

// ==== logic/atop_subsys_top.sv ====
// Atomic filter subsystem top

`timescale 1ns/1ps
`default_nettype none

module atop_subsys_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // AW channel
  input  wire logic                      aw_valid_i,
  output logic                           aw_ready_o,
  input  atop_axi_pkg::id_t              aw_id_i,
  input  atop_axi_pkg::addr_t            aw_addr_i,
  input  atop_axi_pkg::len_t             aw_len_i,
  input  atop_axi_pkg::atop_t            aw_atop_i,
  // W channel
  input  wire logic                      w_valid_i,
  output logic                           w_ready_o,
  input  atop_axi_pkg::data_t            w_data_i,
  input  atop_axi_pkg::strb_t            w_strb_i,
  input  wire logic                      w_last_i,
  // B channel
  output logic                           b_valid_o,
  input  wire logic                      b_ready_i,
  output atop_axi_pkg::id_t              b_id_o,
  output atop_axi_pkg::resp_code_t       b_resp_o,
  // AR channel
  input  wire logic                      ar_valid_i,
  output logic                           ar_ready_o,
  input  atop_axi_pkg::id_t              ar_id_i,
  input  atop_axi_pkg::addr_t            ar_addr_i,
  input  atop_axi_pkg::len_t             ar_len_i,
  // R channel
  output logic                           r_valid_o,
  input  wire logic                      r_ready_i,
  output atop_axi_pkg::id_t              r_id_o,
  output atop_axi_pkg::data_t            r_data_o,
  output atop_axi_pkg::resp_code_t       r_resp_o,
  output logic                           r_last_o
);

  axi_chan_if up_bus ();
  axi_chan_if dn_bus ();

  // Requests into the upstream bundle, full-width INCR only
  assign up_bus.req.aw_valid   = aw_valid_i;
  assign up_bus.req.aw.id      = aw_id_i;
  assign up_bus.req.aw.addr    = aw_addr_i;
  assign up_bus.req.aw.len     = aw_len_i;
  assign up_bus.req.aw.size    = atop_axi_pkg::SIZE_FULL;
  assign up_bus.req.aw.burst   = atop_axi_pkg::BURST_INCR;
  assign up_bus.req.aw.atop    = aw_atop_i;
  assign up_bus.req.w_valid    = w_valid_i;
  assign up_bus.req.w.data     = w_data_i;
  assign up_bus.req.w.strb     = w_strb_i;
  assign up_bus.req.w.last     = w_last_i;
  assign up_bus.req.b_ready    = b_ready_i;
  assign up_bus.req.ar_valid   = ar_valid_i;
  assign up_bus.req.ar.id      = ar_id_i;
  assign up_bus.req.ar.addr    = ar_addr_i;
  assign up_bus.req.ar.len     = ar_len_i;
  assign up_bus.req.ar.size    = atop_axi_pkg::SIZE_FULL;
  assign up_bus.req.ar.burst   = atop_axi_pkg::BURST_INCR;
  assign up_bus.req.r_ready    = r_ready_i;

  // Responses back out
  assign aw_ready_o = up_bus.resp.aw_ready;
  assign w_ready_o  = up_bus.resp.w_ready;
  assign b_valid_o  = up_bus.resp.b_valid;
  assign b_id_o     = up_bus.resp.b.id;
  assign b_resp_o   = up_bus.resp.b.resp;
  assign ar_ready_o = up_bus.resp.ar_ready;
  assign r_valid_o  = up_bus.resp.r_valid;
  assign r_id_o     = up_bus.resp.r.id;
  assign r_data_o   = up_bus.resp.r.data;
  assign r_resp_o   = up_bus.resp.r.resp;
  assign r_last_o   = up_bus.resp.r.last;

  atop_filter atop_filter_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv    (up_bus.slv),
    .mst    (dn_bus.mst)
  );

  burst_mem burst_mem_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv    (dn_bus.slv)
  );

endmodule

`default_nettype wire

// ==== tests/tb_atop_tasks.svh ====
// Testbench driver and check tasks

`ifndef TB_ATOP_TASKS_SVH
`define TB_ATOP_TASKS_SVH

// Cycle limit for every single wait
localparam int wait_limit = 200;

// B response against the expected ID and code
task automatic check_b(input string name, input atop_axi_pkg::b_chan_t exp,
                       input atop_axi_pkg::b_chan_t act);
  n_checks++;
  if (exp !== act) begin
    n_mismatch++;
    $display("MISMATCH %s B: expected id=%h resp=%h, actual id=%h resp=%h",
             name, exp.id, exp.resp, act.id, act.resp);
  end
endtask

// R beat check, data ignored for injected error beats
task automatic check_r(input string name, input atop_axi_pkg::r_chan_t exp,
                       input atop_axi_pkg::r_chan_t act, input bit cmp_data);
  n_checks++;
  if (exp.id !== act.id || exp.resp !== act.resp || exp.last !== act.last ||
      (cmp_data && exp.data !== act.data)) begin
    n_mismatch++;
    $display({"MISMATCH %s R: expected id=%h data=%h resp=%h last=%b, ",
              "actual id=%h data=%h resp=%h last=%b"},
             name, exp.id, exp.data, exp.resp, exp.last,
             act.id, act.data, act.resp, act.last);
  end
endtask

task automatic send_aw(input atop_axi_pkg::id_t id, input atop_axi_pkg::addr_t addr,
                       input atop_axi_pkg::len_t len, input atop_axi_pkg::atop_t atop);
  int cycles;
  cycles = 0;
  @(posedge clk_i);
  aw_valid_i <= 1'b1;
  aw_id_i    <= id;
  aw_addr_i  <= addr;
  aw_len_i   <= len;
  aw_atop_i  <= atop;
  // Ready sampled mid-cycle, transfer on the next rising edge
  do begin
    @(negedge clk_i);
    cycles++;
  end while (!aw_ready_o && cycles < wait_limit);
  if (!aw_ready_o) begin
    n_timeout++;
    $display("Timeout: AW with id %h was not accepted within %0d cycles", id, wait_limit);
  end
  @(posedge clk_i);
  aw_valid_i <= 1'b0;
endtask

task automatic send_ar(input atop_axi_pkg::id_t id, input atop_axi_pkg::addr_t addr,
                       input atop_axi_pkg::len_t len);
  int cycles;
  cycles = 0;
  @(posedge clk_i);
  ar_valid_i <= 1'b1;
  ar_id_i    <= id;
  ar_addr_i  <= addr;
  ar_len_i   <= len;
  do begin
    @(negedge clk_i);
    cycles++;
  end while (!ar_ready_o && cycles < wait_limit);
  if (!ar_ready_o) begin
    n_timeout++;
    $display("Timeout: AR with id %h was not accepted within %0d cycles", id, wait_limit);
  end
  @(posedge clk_i);
  ar_valid_i <= 1'b0;
endtask

// Full W burst, last on the final beat
task automatic send_w(input atop_axi_pkg::data_t data[$], input atop_axi_pkg::strb_t strb);
  int cycles;
  foreach (data[i]) begin
    cycles = 0;
    @(posedge clk_i);
    w_valid_i <= 1'b1;
    w_data_i  <= data[i];
    w_strb_i  <= strb;
    w_last_i  <= (i == data.size() - 1);
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!w_ready_o && cycles < wait_limit);
    if (!w_ready_o) begin
      n_timeout++;
      $display("Timeout: W beat %0d was not accepted within %0d cycles", i, wait_limit);
    end
  end
  @(posedge clk_i);
  w_valid_i <= 1'b0;
  w_last_i  <= 1'b0;
endtask

// One B response, optionally with random ready gaps
task automatic recv_b(input bit gaps, output atop_axi_pkg::b_chan_t b);
  int  cycles;
  bit  done;
  cycles = 0;
  done   = 1'b0;
  b      = '0;
  while (!done && cycles < wait_limit) begin
    @(posedge clk_i);
    b_ready_i <= gaps ? (($random(seed) % 4) != 0) : 1'b1;
    @(negedge clk_i);
    cycles++;
    if (b_valid_o && b_ready_i) begin
      b.id   = b_id_o;
      b.resp = b_resp_o;
      done   = 1'b1;
    end
  end
  @(posedge clk_i);
  b_ready_i <= 1'b0;
  if (!done) begin
    n_timeout++;
    $display("Timeout: no B response within %0d cycles", wait_limit);
  end
endtask

// Collect n R beats, timeout restarts on each beat
task automatic recv_r(input int n, input bit gaps, output atop_axi_pkg::r_chan_t q[$]);
  atop_axi_pkg::r_chan_t beat;
  int cycles;
  q = {};
  cycles = 0;
  while (q.size() < n && cycles < wait_limit) begin
    @(posedge clk_i);
    r_ready_i <= gaps ? (($random(seed) % 4) != 0) : 1'b1;
    @(negedge clk_i);
    cycles++;
    if (r_valid_o && r_ready_i) begin
      beat.id   = r_id_o;
      beat.data = r_data_o;
      beat.resp = r_resp_o;
      beat.last = r_last_o;
      q.push_back(beat);
      cycles = 0;
    end
  end
  @(posedge clk_i);
  r_ready_i <= 1'b0;
  if (q.size() < n) begin
    n_timeout++;
    $display("Timeout: got %0d of %0d R beats", q.size(), n);
  end
endtask

// R must stay idle while ready is offered
task automatic expect_no_r(input string name, input int n);
  @(posedge clk_i);
  r_ready_i <= 1'b1;
  repeat (n) begin
    @(negedge clk_i);
    if (r_valid_o) begin
      n_other++;
      $display("%s: unexpected R beat with id %h", name, r_id_o);
    end
  end
  @(posedge clk_i);
  r_ready_i <= 1'b0;
endtask

`endif

// ==== tests/tb_atop_subsys.sv ====
// Atomic filter subsystem testbench

`timescale 1ns/1ps
`default_nettype none

`include "atop_defs.svh"

module tb_atop_subsys;

  typedef logic [$clog2(`ATOP_MEM_WORDS)-1:0] word_idx_t;

  logic clk_i = 1'b0;
  logic rst_ni;

  // DUT inputs
  logic                aw_valid_i;
  atop_axi_pkg::id_t   aw_id_i;
  atop_axi_pkg::addr_t aw_addr_i;
  atop_axi_pkg::len_t  aw_len_i;
  atop_axi_pkg::atop_t aw_atop_i;
  logic                w_valid_i;
  atop_axi_pkg::data_t w_data_i;
  atop_axi_pkg::strb_t w_strb_i;
  logic                w_last_i;
  logic                b_ready_i;
  logic                ar_valid_i;
  atop_axi_pkg::id_t   ar_id_i;
  atop_axi_pkg::addr_t ar_addr_i;
  atop_axi_pkg::len_t  ar_len_i;
  logic                r_ready_i;

  // DUT outputs
  logic                     aw_ready_o;
  logic                     w_ready_o;
  logic                     b_valid_o;
  atop_axi_pkg::id_t        b_id_o;
  atop_axi_pkg::resp_code_t b_resp_o;
  logic                     ar_ready_o;
  logic                     r_valid_o;
  atop_axi_pkg::id_t        r_id_o;
  atop_axi_pkg::data_t      r_data_o;
  atop_axi_pkg::resp_code_t r_resp_o;
  logic                     r_last_o;

  integer seed;
  int     n_checks   = 0;
  int     n_mismatch = 0;
  int     n_timeout  = 0;
  int     n_other    = 0;

  // Expected memory contents, only written words are ever read
  atop_axi_pkg::data_t model_mem [`ATOP_MEM_WORDS];

  `include "tb_atop_tasks.svh"

  always #20 clk_i = ~clk_i;

  atop_subsys_top atop_subsys_top_i (.*);

  // Word address plus beat, wrapping at the memory depth
  function automatic word_idx_t word_index(input atop_axi_pkg::addr_t addr, input int beat);
    return word_idx_t'(32'(addr) / (`ATOP_DATA_W / 8) + beat);
  endfunction

  function automatic void model_write(input atop_axi_pkg::addr_t addr,
                                      input atop_axi_pkg::data_t data[$],
                                      input atop_axi_pkg::strb_t strb);
    foreach (data[i]) begin
      for (int b = 0; b < `ATOP_DATA_W / 8; b++) begin
        if (strb[b]) begin
          model_mem[word_index(addr, i)][8*b +: 8] = data[i][8*b +: 8];
        end
      end
    end
  endfunction

  // Ordinary write burst with random data, OKAY expected
  task automatic write_burst(input string name, input bit gaps, input atop_axi_pkg::id_t id,
                             input atop_axi_pkg::addr_t addr, input atop_axi_pkg::len_t len);
    atop_axi_pkg::data_t   data[$];
    atop_axi_pkg::b_chan_t b;
    atop_axi_pkg::b_chan_t exp;
    data = {};
    repeat (int'(len) + 1) data.push_back($random(seed));
    send_aw(id, addr, len, '0);
    send_w(data, '1);
    model_write(addr, data, '1);
    recv_b(gaps, b);
    exp = '{id: id, resp: atop_axi_pkg::RESP_OKAY};
    check_b(name, exp, b);
  endtask

  // Read burst compared beat by beat with the model
  task automatic read_check(input string name, input bit gaps, input atop_axi_pkg::id_t id,
                            input atop_axi_pkg::addr_t addr, input atop_axi_pkg::len_t len);
    atop_axi_pkg::r_chan_t beats[$];
    atop_axi_pkg::r_chan_t exp;
    send_ar(id, addr, len);
    recv_r(int'(len) + 1, gaps, beats);
    foreach (beats[i]) begin
      exp = '{id: id, data: model_mem[word_index(addr, i)],
              resp: atop_axi_pkg::RESP_OKAY, last: (i == int'(len))};
      check_r(name, exp, beats[i], 1'b1);
    end
  endtask

  task automatic test_normal(input string name, input bit gaps, input atop_axi_pkg::id_t id,
                             input atop_axi_pkg::addr_t addr);
    write_burst(name, gaps, id, addr, 8'd3);
    read_check(name, gaps, atop_axi_pkg::id_t'(id + 1), addr, 8'd3);
  endtask

  // Store gets one SLVERR B, no R, memory untouched
  task automatic test_atomic_store(input string name);
    atop_axi_pkg::data_t   data[$];
    atop_axi_pkg::b_chan_t b;
    atop_axi_pkg::b_chan_t exp;
    write_burst(name, 1'b0, 4'h1, 12'h100, 8'd1);
    data = {};
    repeat (2) data.push_back($random(seed));
    send_aw(4'h7, 12'h100, 8'd1, {atop_axi_pkg::ATOP_ATOMICSTORE, 4'h0});
    send_w(data, '1);
    recv_b(1'b0, b);
    exp = '{id: 4'h7, resp: atop_axi_pkg::RESP_SLVERR};
    check_b(name, exp, b);
    expect_no_r(name, 10);
    read_check(name, 1'b0, 4'h2, 12'h100, 8'd1);
  endtask

  // Load gets SLVERR B plus len+1 SLVERR R beats
  task automatic test_atomic_load(input string name, input bit gaps, input atop_axi_pkg::id_t id,
                                  input atop_axi_pkg::addr_t addr);
    atop_axi_pkg::data_t   data[$];
    atop_axi_pkg::b_chan_t b;
    atop_axi_pkg::b_chan_t exp_b;
    atop_axi_pkg::r_chan_t beats[$];
    atop_axi_pkg::r_chan_t exp_r;
    data = {};
    repeat (4) data.push_back($random(seed));
    send_aw(id, addr, 8'd3, {atop_axi_pkg::ATOP_ATOMICLOAD, 4'h0});
    send_w(data, '1);
    recv_b(gaps, b);
    exp_b = '{id: id, resp: atop_axi_pkg::RESP_SLVERR};
    check_b(name, exp_b, b);
    recv_r(4, gaps, beats);
    foreach (beats[i]) begin
      exp_r = '{id: id, data: '0, resp: atop_axi_pkg::RESP_SLVERR, last: (i == 3)};
      check_r(name, exp_r, beats[i], 1'b0);
    end
    // A fifth beat would show up here
    expect_no_r(name, 10);
    read_check(name, gaps, 4'h0, addr, 8'd3);
  endtask

  // Atomic AW arrives while an ordinary burst still waits for W
  task automatic test_atomic_behind(input string name);
    atop_axi_pkg::data_t   data_n[$];
    atop_axi_pkg::data_t   data_a[$];
    atop_axi_pkg::b_chan_t b0;
    atop_axi_pkg::b_chan_t b1;
    atop_axi_pkg::b_chan_t tmp;
    atop_axi_pkg::b_chan_t exp;
    data_n = {};
    data_a = {};
    repeat (2) data_n.push_back($random(seed));
    repeat (2) data_a.push_back($random(seed));
    send_aw(4'h5, 12'h180, 8'd1, '0);
    send_aw(4'h6, 12'h180, 8'd1, {atop_axi_pkg::ATOP_ATOMICSTORE, 4'h0});
    send_w(data_n, '1);
    model_write(12'h180, data_n, '1);
    send_w(data_a, '1);
    recv_b(1'b0, b0);
    recv_b(1'b0, b1);
    // Different IDs may complete in either order
    if (b0.id == 4'h6) begin
      tmp = b0;
      b0  = b1;
      b1  = tmp;
    end
    exp = '{id: 4'h5, resp: atop_axi_pkg::RESP_OKAY};
    check_b(name, exp, b0);
    exp = '{id: 4'h6, resp: atop_axi_pkg::RESP_SLVERR};
    check_b(name, exp, b1);
    read_check(name, 1'b0, 4'h4, 12'h180, 8'd1);
  endtask

  // Pending read stays intact around injected beats
  task automatic test_read_during_inject(input string name);
    atop_axi_pkg::data_t   data[$];
    atop_axi_pkg::b_chan_t b;
    atop_axi_pkg::b_chan_t exp_b;
    atop_axi_pkg::r_chan_t beats[$];
    atop_axi_pkg::r_chan_t exp_r;
    int k_atom;
    int k_rd;
    data = {};
    k_atom = 0;
    k_rd = 0;
    repeat (2) data.push_back($random(seed));
    send_ar(4'h2, 12'h040, 8'd3);
    send_aw(4'hc, 12'h0c0, 8'd1, {atop_axi_pkg::ATOP_ATOMICLOAD, 4'h0});
    send_w(data, '1);
    recv_b(1'b0, b);
    exp_b = '{id: 4'hc, resp: atop_axi_pkg::RESP_SLVERR};
    check_b(name, exp_b, b);
    recv_r(6, 1'b0, beats);
    foreach (beats[i]) begin
      if (beats[i].id == 4'hc) begin
        exp_r = '{id: 4'hc, data: '0, resp: atop_axi_pkg::RESP_SLVERR, last: (k_atom == 1)};
        check_r(name, exp_r, beats[i], 1'b0);
        k_atom++;
      end else begin
        exp_r = '{id: 4'h2, data: model_mem[word_index(12'h040, k_rd)],
                  resp: atop_axi_pkg::RESP_OKAY, last: (k_rd == 3)};
        check_r(name, exp_r, beats[i], 1'b1);
        k_rd++;
      end
    end
    if (k_atom != 2 || k_rd != 4) begin
      n_other++;
      $display("%s: expected 2 injected and 4 read beats, got %0d and %0d", name, k_atom, k_rd);
    end
  endtask

  initial begin
    seed       = 32'hb5df;
    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_atop_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    r_ready_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    test_normal("normal_rw", 1'b0, 4'h3, 12'h040);
    test_atomic_store("atomic_store");
    test_atomic_load("atomic_load", 1'b0, 4'hb, 12'h040);
    test_atomic_behind("atomic_behind");
    // Same traffic under random B and R back-pressure
    test_normal("bp_normal_rw", 1'b1, 4'h9, 12'h080);
    test_atomic_load("bp_atomic_load", 1'b1, 4'hd, 12'h080);
    test_read_during_inject("read_during_inject");

    repeat (4) @(posedge clk_i);
    $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
             n_checks, n_mismatch, n_timeout, n_other);
    if (n_mismatch == 0 && n_timeout == 0 && n_other == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== atop_subsys.f ====
+incdir+include
+incdir+tests
logic/atop_axi_pkg.sv
logic/axi_chan_if.sv
logic/stream_reg.sv
logic/atop_filter.sv
logic/burst_mem.sv
logic/atop_subsys_top.sv
tests/tb_atop_subsys.sv

// ==== Makefile ====
# Verilator build and run for the atomic filter subsystem
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_atop_subsys
FILELIST  ?= atop_subsys.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
